//--- hdl/gat_pkg.sv
`default_nettype none

package gat_pkg;

  localparam int MAX_NODES = 16;

  // a projected value sums up to MAX_NODES products of two 8-bit values
  localparam int WH_W   = 16 + $clog2(MAX_NODES);
  localparam int ESUM_W = WH_W + $clog2(MAX_NODES);  // neighbor sum over up to MAX_NODES values

  typedef logic [7:0] feat_t;
  typedef logic [7:0] wgt_t;
  typedef logic [WH_W-1:0] wh_t;
  typedef logic [ESUM_W-1:0] esum_t;
  typedef logic [7:0] out_t;

  typedef enum logic [1:0] {
    IDLE,
    DMVM,
    SPMM,
    AGGR
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- hdl/stage_if.sv
`timescale 1ns/1ps
`default_nettype none

interface stage_if;

  logic dmvm_start;
  logic dmvm_done;
  logic spmm_start;
  logic spmm_done;
  logic aggr_start;
  logic aggr_done;

  modport ctrl (
    output dmvm_start, spmm_start, aggr_start,
    input  dmvm_done, spmm_done, aggr_done
  );

  modport dmvm (input dmvm_start, output dmvm_done);
  modport spmm (input spmm_start, output spmm_done);
  modport aggr (input aggr_start, output aggr_done);

  modport monitor (
    input dmvm_start, dmvm_done, spmm_start, spmm_done, aggr_start, aggr_done
  );

endinterface

`default_nettype wire

//--- hdl/gat_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module gat_ctrl (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic start_i,
  output logic      busy_o,
  output logic      done_o,
  stage_if.ctrl     stg
);

  import gat_pkg::*;

  ctrl_state_t state_q;
  logic        dmvm_start_q;
  logic        spmm_start_q;
  logic        aggr_start_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      dmvm_start_q <= 1'b0;
      spmm_start_q <= 1'b0;
      aggr_start_q <= 1'b0;
    end else begin
      dmvm_start_q <= 1'b0;
      spmm_start_q <= 1'b0;
      aggr_start_q <= 1'b0;
      unique case (state_q)
        IDLE: begin
          if (start_i) begin  // the only place a run is accepted
            state_q      <= DMVM;
            dmvm_start_q <= 1'b1;
          end
        end
        DMVM: begin
          if (stg.dmvm_done) begin
            state_q      <= SPMM;
            spmm_start_q <= 1'b1;
          end
        end
        SPMM: begin
          if (stg.spmm_done) begin
            state_q      <= AGGR;
            aggr_start_q <= 1'b1;
          end
        end
        AGGR: begin
          if (stg.aggr_done) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign busy_o = (state_q != IDLE);
  assign done_o = (state_q == AGGR) && stg.aggr_done;  // lands right after the last output beat

  assign stg.dmvm_start = dmvm_start_q;
  assign stg.spmm_start = spmm_start_q;
  assign stg.aggr_start = aggr_start_q;

endmodule

`default_nettype wire

//--- hdl/dmvm_unit.sv
`timescale 1ns/1ps
`default_nettype none

module dmvm_unit #(
  parameter  int NUM_NODES = 8,
  parameter  int NUM_FEAT  = 4,
  localparam int NODE_W    = $clog2(NUM_NODES),
  localparam int FIDX_W    = $clog2(NUM_FEAT),
  localparam int FADDR_W   = $clog2(NUM_NODES * NUM_FEAT)
) (
  input  wire logic               clk,
  input  wire logic               rst_n,
  stage_if.dmvm                   stg,
  input  wire logic               feat_we_i,
  input  wire logic [FADDR_W-1:0] feat_addr_i,
  input  wire gat_pkg::feat_t     feat_data_i,
  input  wire logic               wgt_we_i,
  input  wire logic [FIDX_W-1:0]  wgt_addr_i,
  input  wire gat_pkg::wgt_t      wgt_data_i,
  output logic                    wh_we_o,
  output logic [NODE_W-1:0]       wh_addr_o,
  output gat_pkg::wh_t            wh_data_o
);

  import gat_pkg::*;

  feat_t feat_mem [NUM_NODES * NUM_FEAT];
  wgt_t  wgt_q [NUM_FEAT];

  logic               busy_q;
  logic               last_q;
  logic               done_q;
  logic [NODE_W-1:0]  node_q;
  logic [FIDX_W-1:0]  feat_q;
  logic [FADDR_W-1:0] addr_q;  // walks node-major, so it equals node * NUM_FEAT + feature
  wh_t                acc_q;
  logic [15:0]        prod;
  wh_t                mac;
  logic               node_end;

  assign prod     = feat_mem[addr_q] * wgt_q[feat_q];
  assign mac      = acc_q + wh_t'(prod);
  assign node_end = (feat_q == FIDX_W'(NUM_FEAT - 1));

  always_ff @(posedge clk) begin
    if (feat_we_i) begin
      feat_mem[feat_addr_i] <= feat_data_i;
    end
    if (wgt_we_i) begin
      wgt_q[wgt_addr_i] <= wgt_data_i;
    end
    if (busy_q && node_end) begin
      wh_addr_o <= node_q;
      wh_data_o <= mac;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q  <= 1'b0;
      last_q  <= 1'b0;
      done_q  <= 1'b0;
      wh_we_o <= 1'b0;
      node_q  <= '0;
      feat_q  <= '0;
      addr_q  <= '0;
      acc_q   <= '0;
    end else begin
      wh_we_o <= 1'b0;
      last_q  <= 1'b0;
      done_q  <= last_q;  // done one cycle after the last write
      if (!busy_q) begin
        if (stg.dmvm_start) begin
          busy_q <= 1'b1;
          node_q <= '0;
          feat_q <= '0;
          addr_q <= '0;
          acc_q  <= '0;
        end
      end else begin
        addr_q <= addr_q + 1'b1;
        if (node_end) begin
          wh_we_o <= 1'b1;
          feat_q  <= '0;
          acc_q   <= '0;
          node_q  <= node_q + 1'b1;
          if (node_q == NODE_W'(NUM_NODES - 1)) begin
            busy_q <= 1'b0;
            last_q <= 1'b1;
          end
        end else begin
          feat_q <= feat_q + 1'b1;
          acc_q  <= mac;
        end
      end
    end
  end

  assign stg.dmvm_done = done_q;

endmodule

`default_nettype wire

//--- hdl/spmm_unit.sv
`timescale 1ns/1ps
`default_nettype none

module spmm_unit #(
  parameter  int NUM_NODES = 8,
  localparam int NODE_W    = $clog2(NUM_NODES)
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  stage_if.spmm                     stg,
  input  wire logic                 adj_we_i,
  input  wire logic [NODE_W-1:0]    adj_addr_i,
  input  wire logic [NUM_NODES-1:0] adj_data_i,
  input  wire logic                 wh_we_i,
  input  wire logic [NODE_W-1:0]    wh_addr_i,
  input  wire gat_pkg::wh_t         wh_data_i,
  output logic                      e_we_o,
  output logic [NODE_W-1:0]         e_addr_o,
  output gat_pkg::esum_t            e_data_o
);

  import gat_pkg::*;

  logic [NUM_NODES-1:0] adj_mem [NUM_NODES];  // bit j of row i marks j as a neighbor of i
  wh_t                  wh_mem [NUM_NODES];

  logic              busy_q;
  logic              last_q;
  logic              done_q;
  logic [NODE_W-1:0] row_q;
  logic [NODE_W-1:0] col_q;
  esum_t             acc_q;
  esum_t             addend;
  esum_t             sum;
  logic              row_end;

  assign addend  = adj_mem[row_q][col_q] ? esum_t'(wh_mem[col_q]) : '0;
  assign sum     = acc_q + addend;
  assign row_end = (col_q == NODE_W'(NUM_NODES - 1));

  always_ff @(posedge clk) begin
    if (adj_we_i) begin
      adj_mem[adj_addr_i] <= adj_data_i;
    end
    if (wh_we_i) begin
      wh_mem[wh_addr_i] <= wh_data_i;
    end
    if (busy_q && row_end) begin
      e_addr_o <= row_q;
      e_data_o <= sum;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      last_q <= 1'b0;
      done_q <= 1'b0;
      e_we_o <= 1'b0;
      row_q  <= '0;
      col_q  <= '0;
      acc_q  <= '0;
    end else begin
      e_we_o <= 1'b0;
      last_q <= 1'b0;
      done_q <= last_q;
      if (!busy_q) begin
        if (stg.spmm_start) begin
          busy_q <= 1'b1;
          row_q  <= '0;
          col_q  <= '0;
          acc_q  <= '0;
        end
      end else if (row_end) begin
        e_we_o <= 1'b1;
        col_q  <= '0;
        acc_q  <= '0;  // empty rows fall out as zero
        row_q  <= row_q + 1'b1;
        if (row_q == NODE_W'(NUM_NODES - 1)) begin
          busy_q <= 1'b0;
          last_q <= 1'b1;
        end
      end else begin
        col_q <= col_q + 1'b1;
        acc_q <= sum;
      end
    end
  end

  assign stg.spmm_done = done_q;

endmodule

`default_nettype wire

//--- hdl/aggr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module aggr_unit #(
  parameter  int NUM_NODES = 8,
  localparam int NODE_W    = $clog2(NUM_NODES)
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  stage_if.aggr                  stg,
  input  wire logic              e_we_i,
  input  wire logic [NODE_W-1:0] e_addr_i,
  input  wire gat_pkg::esum_t    e_data_i,
  output logic                   out_vld_o,
  output logic [NODE_W-1:0]      out_node_o,
  output gat_pkg::out_t          out_data_o
);

  import gat_pkg::*;

  esum_t e_mem [NUM_NODES];

  logic              search_q;
  logic              emit_q;
  logic              fin_q;
  logic              done_q;
  logic [NODE_W-1:0] idx_q;
  esum_t             max_q;
  esum_t             cur;
  esum_t             max_next;
  logic [4:0]        shift_q;
  logic              idx_end;

  // bit length of the maximum minus 8, never below zero
  function automatic logic [4:0] scale_shift(input esum_t v);
    logic [4:0] len;
    len = '0;
    for (int i = 0; i < $bits(esum_t); i++) begin
      if (v[i]) len = 5'(i + 1);
    end
    return (len > 5'd8) ? len - 5'd8 : 5'd0;
  endfunction

  assign cur      = e_mem[idx_q];
  assign max_next = (cur > max_q) ? cur : max_q;
  assign idx_end  = (idx_q == NODE_W'(NUM_NODES - 1));

  always_ff @(posedge clk) begin
    if (e_we_i) begin
      e_mem[e_addr_i] <= e_data_i;
    end
    if (emit_q) begin
      out_node_o <= idx_q;
      out_data_o <= out_t'(cur >> shift_q);  // the largest sum just fits in 8 bits
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      search_q  <= 1'b0;
      emit_q    <= 1'b0;
      fin_q     <= 1'b0;
      done_q    <= 1'b0;
      out_vld_o <= 1'b0;
      idx_q     <= '0;
      max_q     <= '0;
      shift_q   <= '0;
    end else begin
      fin_q     <= 1'b0;
      done_q    <= fin_q;  // fin_q is high with the last beat
      out_vld_o <= emit_q;
      if (search_q) begin
        max_q <= max_next;
        idx_q <= idx_q + 1'b1;
        if (idx_end) begin
          search_q <= 1'b0;
          emit_q   <= 1'b1;
          idx_q    <= '0;
          shift_q  <= scale_shift(max_next);
        end
      end else if (emit_q) begin
        idx_q <= idx_q + 1'b1;
        if (idx_end) begin
          emit_q <= 1'b0;
          fin_q  <= 1'b1;
        end
      end else if (stg.aggr_start) begin
        search_q <= 1'b1;
        idx_q    <= '0;
        max_q    <= '0;
      end
    end
  end

  assign stg.aggr_done = done_q;

endmodule

`default_nettype wire

//--- hdl/stage_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module stage_monitor #(
  parameter  int NUM_NODES = 8,
  localparam int NODE_W    = $clog2(NUM_NODES)
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  stage_if.monitor               stg,
  input  wire logic              wh_we_i,
  input  wire logic [NODE_W-1:0] wh_addr_i,
  input  wire gat_pkg::wh_t      wh_data_i,
  input  wire logic [NODE_W-1:0] capture_addr_i,
  output logic [5:0]             dbg_flags_o,
  output logic [15:0]            dbg_runs_o,
  output gat_pkg::wh_t           dbg_capture_o
);

  logic [5:0] pulses;
  logic       cap_hit;

  // dmvm start sits in bit 5, aggr done in bit 0
  assign pulses = {stg.dmvm_start, stg.dmvm_done,
                   stg.spmm_start, stg.spmm_done,
                   stg.aggr_start, stg.aggr_done};

  assign cap_hit = wh_we_i && (wh_addr_i == capture_addr_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dbg_flags_o   <= '0;
      dbg_runs_o    <= '0;
      dbg_capture_o <= '0;
    end else begin
      dbg_flags_o <= dbg_flags_o | pulses;  // flags stay set until reset
      if (stg.aggr_done) begin
        dbg_runs_o <= dbg_runs_o + 16'd1;
      end
      if (cap_hit) begin
        dbg_capture_o <= wh_data_i;  // later writes overwrite, so the last run wins
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/gat_top.sv
`timescale 1ns/1ps
`default_nettype none

module gat_top #(
  parameter  int NUM_NODES = 8,
  parameter  int NUM_FEAT  = 4,
  localparam int NODE_W    = $clog2(NUM_NODES),
  localparam int FIDX_W    = $clog2(NUM_FEAT),
  localparam int FADDR_W   = $clog2(NUM_NODES * NUM_FEAT)
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 start_i,
  output logic                      busy_o,
  output logic                      done_o,
  input  wire logic                 feat_we_i,
  input  wire logic [FADDR_W-1:0]   feat_addr_i,
  input  wire gat_pkg::feat_t       feat_data_i,
  input  wire logic                 wgt_we_i,
  input  wire logic [FIDX_W-1:0]    wgt_addr_i,
  input  wire gat_pkg::wgt_t        wgt_data_i,
  input  wire logic                 adj_we_i,
  input  wire logic [NODE_W-1:0]    adj_addr_i,
  input  wire logic [NUM_NODES-1:0] adj_data_i,
  input  wire logic [NODE_W-1:0]    capture_addr_i,
  output logic                      out_vld_o,
  output logic [NODE_W-1:0]         out_node_o,
  output gat_pkg::out_t             out_data_o,
  output logic [5:0]                dbg_flags_o,
  output logic [15:0]               dbg_runs_o,
  output gat_pkg::wh_t              dbg_capture_o
);

  import gat_pkg::*;

  logic              wh_we;
  logic [NODE_W-1:0] wh_addr;
  wh_t               wh_data;
  logic              e_we;
  logic [NODE_W-1:0] e_addr;
  esum_t             e_data;

  stage_if stg ();

  gat_ctrl u_ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .start_i (start_i),
    .busy_o  (busy_o),
    .done_o  (done_o),
    .stg     (stg)
  );

  dmvm_unit #(.NUM_NODES(NUM_NODES), .NUM_FEAT(NUM_FEAT)) u_dmvm (
    .clk         (clk),
    .rst_n       (rst_n),
    .stg         (stg),
    .feat_we_i   (feat_we_i),
    .feat_addr_i (feat_addr_i),
    .feat_data_i (feat_data_i),
    .wgt_we_i    (wgt_we_i),
    .wgt_addr_i  (wgt_addr_i),
    .wgt_data_i  (wgt_data_i),
    .wh_we_o     (wh_we),
    .wh_addr_o   (wh_addr),
    .wh_data_o   (wh_data)
  );

  spmm_unit #(.NUM_NODES(NUM_NODES)) u_spmm (
    .clk        (clk),
    .rst_n      (rst_n),
    .stg        (stg),
    .adj_we_i   (adj_we_i),
    .adj_addr_i (adj_addr_i),
    .adj_data_i (adj_data_i),
    .wh_we_i    (wh_we),
    .wh_addr_i  (wh_addr),
    .wh_data_i  (wh_data),
    .e_we_o     (e_we),
    .e_addr_o   (e_addr),
    .e_data_o   (e_data)
  );

  aggr_unit #(.NUM_NODES(NUM_NODES)) u_aggr (
    .clk        (clk),
    .rst_n      (rst_n),
    .stg        (stg),
    .e_we_i     (e_we),
    .e_addr_i   (e_addr),
    .e_data_i   (e_data),
    .out_vld_o  (out_vld_o),
    .out_node_o (out_node_o),
    .out_data_o (out_data_o)
  );

  stage_monitor #(.NUM_NODES(NUM_NODES)) u_monitor (
    .clk            (clk),
    .rst_n          (rst_n),
    .stg            (stg),
    .wh_we_i        (wh_we),
    .wh_addr_i      (wh_addr),
    .wh_data_i      (wh_data),
    .capture_addr_i (capture_addr_i),
    .dbg_flags_o    (dbg_flags_o),
    .dbg_runs_o     (dbg_runs_o),
    .dbg_capture_o  (dbg_capture_o)
  );

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;  // half period high, half low
  end

endmodule

`default_nettype wire

//--- tests/gat_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gat_tb;

  import gat_pkg::*;

  localparam int NUM_NODES   = 8;
  localparam int NUM_FEAT    = 4;
  localparam int NODE_W      = $clog2(NUM_NODES);
  localparam int FIDX_W      = $clog2(NUM_FEAT);
  localparam int FADDR_W     = $clog2(NUM_NODES * NUM_FEAT);
  localparam int TIMEOUT     = 2000;
  localparam int MODE_RANDOM = 0;
  localparam int MODE_SMALL  = 1;
  localparam int MODE_EDGE   = 2;

  logic                 clk;
  logic                 rst_n;
  logic                 start_i;
  logic                 busy_o;
  logic                 done_o;
  logic                 feat_we_i;
  logic [FADDR_W-1:0]   feat_addr_i;
  feat_t                feat_data_i;
  logic                 wgt_we_i;
  logic [FIDX_W-1:0]    wgt_addr_i;
  wgt_t                 wgt_data_i;
  logic                 adj_we_i;
  logic [NODE_W-1:0]    adj_addr_i;
  logic [NUM_NODES-1:0] adj_data_i;
  logic [NODE_W-1:0]    capture_addr_i;
  logic                 out_vld_o;
  logic [NODE_W-1:0]    out_node_o;
  out_t                 out_data_o;
  logic [5:0]           dbg_flags_o;
  logic [15:0]          dbg_runs_o;
  wh_t                  dbg_capture_o;

  // model state for the current run
  int unsigned          feat_m [NUM_NODES * NUM_FEAT];
  int unsigned          wgt_m [NUM_FEAT];
  logic [NUM_NODES-1:0] adj_m [NUM_NODES];
  longint unsigned      wh_m [NUM_NODES];
  longint unsigned      e_m [NUM_NODES];
  longint unsigned      exp_out [NUM_NODES];
  int                   shift_m;
  int                   runs_done;

  tb_clk_gen #(.PERIOD_NS(100)) u_clk_gen (.clk_o(clk));

  gat_top #(.NUM_NODES(NUM_NODES), .NUM_FEAT(NUM_FEAT)) UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (start_i),
    .busy_o         (busy_o),
    .done_o         (done_o),
    .feat_we_i      (feat_we_i),
    .feat_addr_i    (feat_addr_i),
    .feat_data_i    (feat_data_i),
    .wgt_we_i       (wgt_we_i),
    .wgt_addr_i     (wgt_addr_i),
    .wgt_data_i     (wgt_data_i),
    .adj_we_i       (adj_we_i),
    .adj_addr_i     (adj_addr_i),
    .adj_data_i     (adj_data_i),
    .capture_addr_i (capture_addr_i),
    .out_vld_o      (out_vld_o),
    .out_node_o     (out_node_o),
    .out_data_o     (out_data_o),
    .dbg_flags_o    (dbg_flags_o),
    .dbg_runs_o     (dbg_runs_o),
    .dbg_capture_o  (dbg_capture_o)
  );

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_cond(input bit ok, input string what);
    assert (ok) else begin
      $display("ERROR %s", what);
      abort_run();
    end
  endtask

  task automatic make_stimulus(input int mode);
    int unsigned v;
    for (int i = 0; i < NUM_NODES * NUM_FEAT; i++) begin
      v = (mode == MODE_SMALL) ? $urandom_range(0, 3) : $urandom_range(0, 255);
      feat_m[i] = (mode == MODE_EDGE) ? (v | 32'h80) : v;  // top bit forces a large maximum
    end
    for (int f = 0; f < NUM_FEAT; f++) begin
      v = (mode == MODE_SMALL) ? $urandom_range(0, 3) : $urandom_range(0, 255);
      wgt_m[f] = (mode == MODE_EDGE) ? (v | 32'h80) : v;
    end
    for (int i = 0; i < NUM_NODES; i++) begin
      adj_m[i] = NUM_NODES'($urandom());
      if (mode == MODE_SMALL) adj_m[i][i] = 1'b0;  // at most seven neighbors keeps sums under 256
    end
    if (mode == MODE_EDGE) begin
      adj_m[0]             = '0;
      adj_m[NUM_NODES - 1] = '1;
    end
  endtask

  function automatic void compute_model();
    longint unsigned acc;
    longint unsigned max_e;
    max_e = 0;
    for (int i = 0; i < NUM_NODES; i++) begin
      acc = 0;
      for (int f = 0; f < NUM_FEAT; f++) begin
        acc += longint'(feat_m[i * NUM_FEAT + f]) * longint'(wgt_m[f]);
      end
      wh_m[i] = acc;
    end
    for (int i = 0; i < NUM_NODES; i++) begin
      acc = 0;
      for (int j = 0; j < NUM_NODES; j++) begin
        if (adj_m[i][j]) acc += wh_m[j];
      end
      e_m[i] = acc;
      if (acc > max_e) max_e = acc;
    end
    shift_m = 0;
    while ((max_e >> shift_m) > 255) shift_m++;  // smallest shift that fits the maximum in 8 bits
    for (int i = 0; i < NUM_NODES; i++) begin
      exp_out[i] = e_m[i] >> shift_m;
    end
  endfunction

  task automatic load_memories();
    for (int i = 0; i < NUM_NODES * NUM_FEAT; i++) begin
      @(posedge clk);
      feat_we_i   <= 1'b1;
      feat_addr_i <= FADDR_W'(i);
      feat_data_i <= feat_t'(feat_m[i]);
    end
    @(posedge clk);
    feat_we_i <= 1'b0;
    for (int f = 0; f < NUM_FEAT; f++) begin
      @(posedge clk);
      wgt_we_i   <= 1'b1;
      wgt_addr_i <= FIDX_W'(f);
      wgt_data_i <= wgt_t'(wgt_m[f]);
    end
    @(posedge clk);
    wgt_we_i <= 1'b0;
    for (int i = 0; i < NUM_NODES; i++) begin
      @(posedge clk);
      adj_we_i   <= 1'b1;
      adj_addr_i <= NODE_W'(i);
      adj_data_i <= adj_m[i];
    end
    @(posedge clk);
    adj_we_i <= 1'b0;
  endtask

  task automatic run_and_check(input int mode, input bit poke_busy);
    int waited;
    make_stimulus(mode);
    compute_model();
    load_memories();
    @(posedge clk);
    start_i <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
    @(negedge clk);
    check_value("busy_o", busy_o, 1);
    if (poke_busy) begin
      @(posedge clk);
      start_i <= 1'b1;  // must be dropped by the busy controller
      @(posedge clk);
      start_i <= 1'b0;
    end
    waited = 0;
    while (!out_vld_o && waited < TIMEOUT) begin
      @(negedge clk);
      check_value("done_o", done_o, 0);
      waited++;
    end
    check_cond(out_vld_o, "timed out waiting for the first out_vld_o beat");
    for (int n = 0; n < NUM_NODES; n++) begin
      check_value("out_vld_o", out_vld_o, 1);
      check_value("out_node_o", out_node_o, n);
      check_value($sformatf("out_data_o node %0d", n), out_data_o, exp_out[n]);
      if (mode == MODE_SMALL) begin
        check_value($sformatf("out_data_o unscaled node %0d", n), out_data_o, e_m[n]);
      end
      if (mode == MODE_EDGE && n == NUM_NODES - 1) begin
        // the full row holds the maximum, which keeps 8 significant bits after scaling
        check_cond(out_data_o[7], "full-range maximum was shifted further than needed");
      end
      check_value("done_o", done_o, 0);
      @(negedge clk);
    end
    check_value("out_vld_o", out_vld_o, 0);
    check_value("done_o", done_o, 1);
    runs_done++;
    @(negedge clk);
    check_value("done_o", done_o, 0);
    check_value("busy_o", busy_o, 0);
    if (poke_busy) begin
      // a queued second start would show up as a new busy period here
      repeat (2 * NUM_NODES * NUM_FEAT) begin
        @(negedge clk);
        check_value("busy_o", busy_o, 0);
        check_value("out_vld_o", out_vld_o, 0);
      end
    end
  endtask

  initial begin
    void'($urandom(64));
    rst_n          = 1'b0;
    start_i        = 1'b0;
    feat_we_i      = 1'b0;
    feat_addr_i    = '0;
    feat_data_i    = '0;
    wgt_we_i       = 1'b0;
    wgt_addr_i     = '0;
    wgt_data_i     = '0;
    adj_we_i       = 1'b0;
    adj_addr_i     = '0;
    adj_data_i     = '0;
    capture_addr_i = NODE_W'($urandom_range(0, NUM_NODES - 1));
    runs_done      = 0;

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("busy_o", busy_o, 0);
    check_value("done_o", done_o, 0);
    check_value("out_vld_o", out_vld_o, 0);
    check_value("dbg_flags_o", dbg_flags_o, 0);
    check_value("dbg_runs_o", dbg_runs_o, 0);
    check_value("dbg_capture_o", dbg_capture_o, 0);

    run_and_check(MODE_RANDOM, 1'b0);
    run_and_check(MODE_RANDOM, 1'b0);
    run_and_check(MODE_SMALL, 1'b0);
    run_and_check(MODE_EDGE, 1'b0);
    run_and_check(MODE_RANDOM, 1'b1);
    run_and_check(MODE_RANDOM, 1'b0);

    @(negedge clk);
    check_value("dbg_flags_o", dbg_flags_o, 6'h3f);
    check_value("dbg_runs_o", dbg_runs_o, runs_done);
    check_value("dbg_capture_o", dbg_capture_o, wh_m[capture_addr_i]);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- gat.f
hdl/gat_pkg.sv
hdl/stage_if.sv
hdl/gat_ctrl.sv
hdl/dmvm_unit.sv
hdl/spmm_unit.sv
hdl/aggr_unit.sv
hdl/stage_monitor.sv
hdl/gat_top.sv
tests/tb_clk_gen.sv
tests/gat_tb.sv

//--- Bender.yml
package:
  name: gat

sources:
  - hdl/gat_pkg.sv
  - hdl/stage_if.sv
  - hdl/gat_ctrl.sv
  - hdl/dmvm_unit.sv
  - hdl/spmm_unit.sv
  - hdl/aggr_unit.sv
  - hdl/stage_monitor.sv
  - hdl/gat_top.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/gat_tb.sv
